// File: source/cpu_macros.svh
// Core sizes and APB register map, included by the RTL, the package and the testbench
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_XLEN       16
`define CPU_NREGS      8
`define CPU_REG_AW     $clog2(`CPU_NREGS)
`define CPU_IMEM_DEPTH 256
`define CPU_IMEM_AW    $clog2(`CPU_IMEM_DEPTH)
`define CPU_DMEM_DEPTH 256
`define CPU_DMEM_AW    $clog2(`CPU_DMEM_DEPTH)

// APB bus widths and register offsets
`define CPU_APB_AW     8
`define CPU_APB_DW     32
`define REG_CTRL       'h00
`define REG_STATUS     'h04
`define REG_IMEM_ADDR  'h08
`define REG_IMEM_DATA  'h0C
`define REG_SEL        'h10
`define REG_DATA       'h14

`endif

// File: source/cpuPkg.sv
// Shared opcode, ALU and decoded-control types, imported by the pipeline stages
`default_nettype none
`include "cpu_macros.svh"

package cpuPkg;

   // Top four bits of every instruction
   typedef enum logic [3:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_XOR  = 4'h4,
      OP_ADDI = 4'h5,
      OP_LBI  = 4'h6,
      OP_LD   = 4'h7,
      OP_ST   = 4'h8,
      OP_BEQZ = 4'h9,
      OP_HALT = 4'hF
   } opcodeT;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_XOR,
      ALU_PASSB
   } aluOpT;

   // All zero is a bubble
   typedef struct packed {
      aluOpT                 aluOp;
      logic                  useImm;
      logic                  regWrt;
      logic                  memRd;
      logic                  memWrt;
      logic                  isBranch;
      logic                  isHalt;
      logic [`CPU_REG_AW-1:0] rd;
   } ctrlT;

   localparam logic [`CPU_XLEN-1:0] NOP_INSTR = {OP_NOP, {(`CPU_XLEN-4){1'b0}}};

endpackage

`default_nettype wire

// File: source/cpuDebugIf.sv
// Debug link between the APB register block and the pipeline stages
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

interface cpuDebugIf;

   logic                    run;
   logic                    halted;
   logic                    imemWrEn;
   logic [`CPU_IMEM_AW-1:0] imemAddr;
   logic [`CPU_XLEN-1:0]    imemData;
   logic [`CPU_REG_AW-1:0]  regSel;
   logic [`CPU_XLEN-1:0]    regData;

   // Register block side
   modport ctrl (
      output run, imemWrEn, imemAddr, imemData, regSel,
      input  halted, regData
   );

   // Pipeline side, shared out among fetch, decode and memory/writeback
   modport core (
      input  run, imemWrEn, imemAddr, imemData, regSel,
      output halted, regData
   );

endinterface

`default_nettype wire

// File: source/cpuDebugRegs.sv
// APB slave for run control, instruction memory loading and register readback
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpuDebugRegs (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`CPU_APB_AW-1:0] paddr,
   input  logic [`CPU_APB_DW-1:0] pwdata,
   output logic [`CPU_APB_DW-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   cpuDebugIf.ctrl                dbg
);

   logic       access;
   logic       wrEn;
   logic       known;
   logic [1:0] startCnt;

   assign access  = psel && penable;
   assign wrEn    = access && pwrite;
   assign pready  = 1'b1;
   assign pslverr = access && !known;

   // Load port goes straight to the instruction memory
   assign dbg.imemWrEn = wrEn && (paddr == `REG_IMEM_DATA);
   assign dbg.imemData = pwdata[`CPU_XLEN-1:0];

   always_comb begin
      known  = 1'b1;
      prdata = '0;
      case (paddr)
         `REG_CTRL:      prdata[0] = dbg.run;
         `REG_STATUS:    prdata[0] = dbg.halted;
         `REG_IMEM_ADDR: prdata[`CPU_IMEM_AW-1:0] = dbg.imemAddr;
         // Write-only port, reads back as zero
         `REG_IMEM_DATA: prdata = '0;
         `REG_SEL:       prdata[`CPU_REG_AW-1:0] = dbg.regSel;
         `REG_DATA:      prdata[`CPU_XLEN-1:0] = dbg.regData;
         default:        known = 1'b0;
      endcase
   end

   // A start drops run for two cycles so every stage flushes before the PC restarts
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         dbg.run      <= 1'b0;
         startCnt     <= 2'd0;
         dbg.imemAddr <= '0;
         dbg.regSel   <= '0;
      end else begin
         if (wrEn && (paddr == `REG_CTRL)) begin
            dbg.run  <= 1'b0;
            startCnt <= pwdata[0] ? 2'd2 : 2'd0;
         end else if (startCnt != 2'd0) begin
            startCnt <= startCnt - 2'd1;
            dbg.run  <= (startCnt == 2'd1);
         end

         if (wrEn && (paddr == `REG_IMEM_ADDR)) begin
            dbg.imemAddr <= pwdata[`CPU_IMEM_AW-1:0];
         end else if (dbg.imemWrEn) begin
            dbg.imemAddr <= dbg.imemAddr + 1'b1;
         end

         if (wrEn && (paddr == `REG_SEL)) begin
            dbg.regSel <= pwdata[`CPU_REG_AW-1:0];
         end
      end
   end

endmodule

`default_nettype wire

// File: source/fetchStage.sv
// Fetch stage with PC, instruction memory and the fetch-to-decode register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module fetchStage import cpuPkg::*; (
   input  logic                 clk,
   input  logic                 rstN,
   cpuDebugIf.core              dbg,
   input  logic                 stall,
   input  logic                 brTaken,
   input  logic [`CPU_XLEN-1:0] brTarget,
   output logic [`CPU_XLEN-1:0] instrD,
   output logic [`CPU_XLEN-1:0] pcIncD
);

   logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH];
   logic [`CPU_XLEN-1:0] pc;
   logic                 validD;
   logic                 haltSeen;
   logic                 haltInD;

   assign haltInD = validD && (instrD[`CPU_XLEN-1 -: 4] == OP_HALT);

   // Loaded only by the debug block
   always_ff @(posedge clk) begin
      if (dbg.imemWrEn) begin
         imem[dbg.imemAddr] <= dbg.imemData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc       <= '0;
         validD   <= 1'b0;
         haltSeen <= 1'b0;
         instrD   <= NOP_INSTR;
      end else if (!dbg.run) begin
         pc       <= '0;
         validD   <= 1'b0;
         haltSeen <= 1'b0;
         instrD   <= NOP_INSTR;
      end else if (brTaken) begin
         // Squash the word being fetched
         pc     <= brTarget;
         validD <= 1'b0;
         instrD <= NOP_INSTR;
      end else if (stall) begin
         pc <= pc;
      end else if (haltSeen || haltInD) begin
         haltSeen <= 1'b1;
         validD   <= 1'b0;
         instrD   <= NOP_INSTR;
      end else begin
         pc     <= pc + 1'b1;
         validD <= 1'b1;
         instrD <= imem[pc[`CPU_IMEM_AW-1:0]];
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         pcIncD <= pc + 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: source/decodeStage.sv
// Decode stage with register file, hazard stall and the decode-to-execute register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module decodeStage import cpuPkg::*; (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic [`CPU_XLEN-1:0]   instrD,
   input  logic [`CPU_XLEN-1:0]   pcIncD,
   input  logic                   wbEn,
   input  logic [`CPU_REG_AW-1:0] wbReg,
   input  logic [`CPU_XLEN-1:0]   wbData,
   cpuDebugIf.core                dbg,
   output logic                   stall,
   output ctrlT                   ctrlX,
   output logic [`CPU_XLEN-1:0]   opAX,
   output logic [`CPU_XLEN-1:0]   opBX,
   output logic [`CPU_XLEN-1:0]   storeX,
   output logic [`CPU_XLEN-1:0]   pcIncX
);

   logic [`CPU_XLEN-1:0]   regs [`CPU_NREGS];
   opcodeT                 op;
   logic [`CPU_REG_AW-1:0] fieldRd, fieldRs, fieldRt;
   logic [`CPU_XLEN-1:0]   immVal;
   logic [`CPU_XLEN-1:0]   valRs, valRt, valRd;
   ctrlT                   ctrl;
   logic                   useRs, useRt, useRd;
   logic                   hazRs, hazRt, hazRd;
   logic                   validX;
   logic                   wrM;
   logic [`CPU_REG_AW-1:0] rdM;

   assign op      = opcodeT'(instrD[`CPU_XLEN-1 -: 4]);
   assign fieldRd = instrD[11:9];
   assign fieldRs = instrD[8:6];
   assign fieldRt = instrD[5:3];

   always_comb begin
      ctrl    = '0;
      ctrl.rd = fieldRd;
      useRs   = 1'b0;
      useRt   = 1'b0;
      useRd   = 1'b0;
      immVal  = {{(`CPU_XLEN-6){instrD[5]}}, instrD[5:0]};
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            ctrl.regWrt = 1'b1;
            useRs       = 1'b1;
            useRt       = 1'b1;
            case (op)
               OP_SUB:  ctrl.aluOp = ALU_SUB;
               OP_AND:  ctrl.aluOp = ALU_AND;
               OP_XOR:  ctrl.aluOp = ALU_XOR;
               default: ctrl.aluOp = ALU_ADD;
            endcase
         end
         OP_ADDI: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrt = 1'b1;
            useRs       = 1'b1;
         end
         OP_LBI: begin
            ctrl.aluOp  = ALU_PASSB;
            ctrl.useImm = 1'b1;
            ctrl.regWrt = 1'b1;
            immVal      = {{(`CPU_XLEN-9){instrD[8]}}, instrD[8:0]};
         end
         OP_LD: begin
            ctrl.useImm = 1'b1;
            ctrl.regWrt = 1'b1;
            ctrl.memRd  = 1'b1;
            useRs       = 1'b1;
         end
         // Store data comes from rd
         OP_ST: begin
            ctrl.useImm = 1'b1;
            ctrl.memWrt = 1'b1;
            useRs       = 1'b1;
            useRd       = 1'b1;
         end
         OP_BEQZ: begin
            ctrl.useImm   = 1'b1;
            ctrl.isBranch = 1'b1;
            useRs         = 1'b1;
         end
         OP_HALT: ctrl.isHalt = 1'b1;
         default: ctrl = '0;
      endcase
   end

   // Register file reads see this cycle's writeback
   assign valRs = (wbEn && (wbReg == fieldRs)) ? wbData : regs[fieldRs];
   assign valRt = (wbEn && (wbReg == fieldRt)) ? wbData : regs[fieldRt];
   assign valRd = (wbEn && (wbReg == fieldRd)) ? wbData : regs[fieldRd];

   assign dbg.regData = regs[dbg.regSel];

   always_ff @(posedge clk) begin
      if (wbEn) begin
         regs[wbReg] <= wbData;
      end
   end

   // Pending writers sit in execute (ctrlX) or memory (shadow copy)
   assign hazRs = useRs && ((validX && ctrlX.regWrt && (ctrlX.rd == fieldRs))
                            || (wrM && (rdM == fieldRs)));
   assign hazRt = useRt && ((validX && ctrlX.regWrt && (ctrlX.rd == fieldRt))
                            || (wrM && (rdM == fieldRt)));
   assign hazRd = useRd && ((validX && ctrlX.regWrt && (ctrlX.rd == fieldRd))
                            || (wrM && (rdM == fieldRd)));
   assign stall = hazRs || hazRt || hazRd;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ctrlX  <= '0;
         validX <= 1'b0;
         wrM    <= 1'b0;
         rdM    <= '0;
      end else begin
         wrM <= validX && ctrlX.regWrt;
         rdM <= ctrlX.rd;
         if (!dbg.run || stall) begin
            ctrlX  <= '0;
            validX <= 1'b0;
         end else begin
            ctrlX  <= ctrl;
            validX <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      opAX   <= valRs;
      opBX   <= ctrl.useImm ? immVal : valRt;
      storeX <= valRd;
      pcIncX <= pcIncD;
   end

endmodule

`default_nettype wire

// File: source/executeStage.sv
// Execute stage with ALU, branch resolution and the execute-to-memory register
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module executeStage import cpuPkg::*; (
   input  logic                 clk,
   input  logic                 rstN,
   input  ctrlT                 ctrlX,
   input  logic [`CPU_XLEN-1:0] opAX,
   input  logic [`CPU_XLEN-1:0] opBX,
   input  logic [`CPU_XLEN-1:0] storeX,
   input  logic [`CPU_XLEN-1:0] pcIncX,
   output logic                 brTaken,
   output logic [`CPU_XLEN-1:0] brTarget,
   output ctrlT                 ctrlM,
   output logic [`CPU_XLEN-1:0] resultM,
   output logic [`CPU_XLEN-1:0] storeM
);

   logic [`CPU_XLEN-1:0] aluOut;
   // Set for the cycle after a taken branch, when the delay-slot instruction is here
   logic                 killX;

   always_comb begin
      case (ctrlX.aluOp)
         ALU_ADD:   aluOut = opAX + opBX;
         ALU_SUB:   aluOut = opAX - opBX;
         ALU_AND:   aluOut = opAX & opBX;
         ALU_XOR:   aluOut = opAX ^ opBX;
         ALU_PASSB: aluOut = opBX;
         default:   aluOut = opBX;
      endcase
   end

   assign brTaken  = ctrlX.isBranch && !killX && (opAX == '0);
   assign brTarget = pcIncX + opBX;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         killX <= 1'b0;
         ctrlM <= '0;
      end else begin
         killX <= brTaken;
         ctrlM <= killX ? '0 : ctrlX;
      end
   end

   always_ff @(posedge clk) begin
      resultM <= aluOut;
      storeM  <= storeX;
   end

endmodule

`default_nettype wire

// File: source/memWbStage.sv
// Memory and writeback stage with data memory, writeback register and halt flag
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module memWbStage import cpuPkg::*; (
   input  logic                   clk,
   input  logic                   rstN,
   input  ctrlT                   ctrlM,
   input  logic [`CPU_XLEN-1:0]   resultM,
   input  logic [`CPU_XLEN-1:0]   storeM,
   cpuDebugIf.core                dbg,
   output logic                   wbEn,
   output logic [`CPU_REG_AW-1:0] wbReg,
   output logic [`CPU_XLEN-1:0]   wbData
);

   logic [`CPU_XLEN-1:0]    dmem [`CPU_DMEM_DEPTH];
   logic [`CPU_DMEM_AW-1:0] addr;
   logic                    validW;
   logic                    regWrtW;

   assign addr = resultM[`CPU_DMEM_AW-1:0];
   assign wbEn = validW && regWrtW;

   // Stores are dropped while the core is stopped or flushing
   always_ff @(posedge clk) begin
      if (dbg.run && ctrlM.memWrt) begin
         dmem[addr] <= storeM;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         validW     <= 1'b0;
         regWrtW    <= 1'b0;
         dbg.halted <= 1'b0;
      end else begin
         validW  <= dbg.run && (ctrlM != '0);
         regWrtW <= dbg.run && ctrlM.regWrt;
         if (!dbg.run) begin
            dbg.halted <= 1'b0;
         end else if (ctrlM.isHalt) begin
            dbg.halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      wbReg  <= ctrlM.rd;
      wbData <= ctrlM.memRd ? dmem[addr] : resultM;
   end

endmodule

`default_nettype wire

// File: source/cpuCore.sv
// Top level of the pipelined core, APB debug block beside the five stages
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpuCore import cpuPkg::*; (
   input  logic                   clk,
   input  logic                   rstN,
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [`CPU_APB_AW-1:0] paddr,
   input  logic [`CPU_APB_DW-1:0] pwdata,
   output logic [`CPU_APB_DW-1:0] prdata,
   output logic                   pready,
   output logic                   pslverr,
   output logic                   halted
);

   logic                   stall;
   logic                   brTaken;
   logic [`CPU_XLEN-1:0]   brTarget;
   logic [`CPU_XLEN-1:0]   instrD;
   logic [`CPU_XLEN-1:0]   pcIncD;
   ctrlT                   ctrlX;
   logic [`CPU_XLEN-1:0]   opAX;
   logic [`CPU_XLEN-1:0]   opBX;
   logic [`CPU_XLEN-1:0]   storeX;
   logic [`CPU_XLEN-1:0]   pcIncX;
   ctrlT                   ctrlM;
   logic [`CPU_XLEN-1:0]   resultM;
   logic [`CPU_XLEN-1:0]   storeM;
   logic                   wbEn;
   logic [`CPU_REG_AW-1:0] wbReg;
   logic [`CPU_XLEN-1:0]   wbData;

   cpuDebugIf dbgIf ();

   assign halted = dbgIf.halted;

   cpuDebugRegs cpuDebugRegs_inst (
      .clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .dbg(dbgIf.ctrl)
   );

   fetchStage fetchStage_inst (
      .clk(clk), .rstN(rstN), .dbg(dbgIf.core), .stall(stall), .brTaken(brTaken),
      .brTarget(brTarget), .instrD(instrD), .pcIncD(pcIncD)
   );

   decodeStage decodeStage_inst (
      .clk(clk), .rstN(rstN), .instrD(instrD), .pcIncD(pcIncD), .wbEn(wbEn),
      .wbReg(wbReg), .wbData(wbData), .dbg(dbgIf.core), .stall(stall), .ctrlX(ctrlX),
      .opAX(opAX), .opBX(opBX), .storeX(storeX), .pcIncX(pcIncX)
   );

   executeStage executeStage_inst (
      .clk(clk), .rstN(rstN), .ctrlX(ctrlX), .opAX(opAX), .opBX(opBX), .storeX(storeX),
      .pcIncX(pcIncX), .brTaken(brTaken), .brTarget(brTarget), .ctrlM(ctrlM),
      .resultM(resultM), .storeM(storeM)
   );

   memWbStage memWbStage_inst (
      .clk(clk), .rstN(rstN), .ctrlM(ctrlM), .resultM(resultM), .storeM(storeM),
      .dbg(dbgIf.core), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
   );

endmodule

`default_nettype wire

// File: tb/cpu_props.sv
// Assertions on APB and pipeline rules, bound into cpuCore
`timescale 1ns/1ps
`default_nettype none

module cpuProps (
   input wire logic clk,
   input wire logic rstN,
   input wire logic penable,
   input wire logic pready,
   input wire logic run,
   input wire logic halted,
   input wire logic validX,
   input wire logic wbEn,
   input wire logic stall
);

   // Zero wait states
   readyOnAccess: assert property (@(posedge clk) disable iff (!rstN) penable |-> pready)
      else $error("pready low in an access cycle");

   // A register write traces back to a valid instruction in execute two cycles before
   noWriteFromBubble: assert property (@(posedge clk) disable iff (!rstN)
      wbEn |-> $past(validX, 2))
      else $error("register write from an invalid stage");

   // Halt only clears after run was dropped by a start
   haltedHolds: assert property (@(posedge clk) disable iff (!rstN)
      $fell(halted) |-> !$past(run))
      else $error("halted fell while run was high");

   shortStall: assert property (@(posedge clk) disable iff (!rstN)
      !(stall && $past(stall) && $past(stall, 2)))
      else $error("stall lasted more than two cycles");

endmodule

bind cpuCore cpuProps cpuProps_inst (
   .clk(clk), .rstN(rstN), .penable(penable), .pready(pready), .run(dbgIf.run),
   .halted(halted), .validX(decodeStage_inst.validX),
   .wbEn(wbEn), .stall(stall)
);

`default_nettype wire

// File: tb/cpuTb.sv
// Testbench for cpuCore, runs the programs from the data file over APB and checks registers
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpuTb;

   logic                   clk;
   logic                   rstN;
   logic                   psel;
   logic                   penable;
   logic                   pwrite;
   logic [`CPU_APB_AW-1:0] paddr;
   logic [`CPU_APB_DW-1:0] pwdata;
   logic [`CPU_APB_DW-1:0] prdata;
   logic                   pready;
   logic                   pslverr;
   logic                   halted;

   logic [31:0]            testData [0:255];
   logic [`CPU_XLEN-1:0]   expRegs [`CPU_NREGS];
   int                     cycles = 0;
   int                     cycleLimit = 0;

   cpuCore cpuCore_inst (
      .clk(clk), .rstN(rstN), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
      .pslverr(pslverr), .halted(halted)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Limit is set once the data file has been sized
   always @(posedge clk) begin
      cycles++;
      if (cycleLimit != 0 && cycles > cycleLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
         $display("Something failed");
         $fatal(1, "Simulation timed out");
      end
   end

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
         $display("Something failed");
         $fatal(1, "Value mismatch");
      end
   endtask

   // One setup and one access cycle, response sampled inside the access cycle
   task automatic apbAccess(input logic wr, input logic [`CPU_APB_AW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk);
      penable = 1'b1;
      #1;
      rdata = prdata;
      err   = pslverr;
      checkValue("pready", {31'b0, pready}, 32'd1);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apbWrite(input logic [`CPU_APB_AW-1:0] addr, input logic [31:0] data);
      logic [31:0] rdata;
      logic        err;
      apbAccess(1'b1, addr, data, rdata, err);
      checkValue("pslverr", {31'b0, err}, 32'd0);
   endtask

   task automatic apbRead(input logic [`CPU_APB_AW-1:0] addr, output logic [31:0] data);
      logic err;
      apbAccess(1'b0, addr, 32'd0, data, err);
      checkValue("pslverr", {31'b0, err}, 32'd0);
   endtask

   // Start the core and poll status until it reports halt
   task automatic runToHalt;
      logic [31:0] status;
      apbWrite(`REG_CTRL, 32'd1);
      apbRead(`REG_STATUS, status);
      checkValue("status after start", status, 32'd0);
      while (status[0] !== 1'b1) begin
         apbRead(`REG_STATUS, status);
      end
      checkValue("halted", {31'b0, halted}, 32'd1);
   endtask

   task automatic compareRegs;
      logic [31:0] data;
      for (int r = 0; r < `CPU_NREGS; r++) begin
         apbWrite(`REG_SEL, r);
         apbRead(`REG_DATA, data);
         checkValue($sformatf("r%0d", r), data, {16'b0, expRegs[r]});
      end
   endtask

   initial begin
      int          idx;
      int          words;
      int          programs;
      int          count;
      logic [31:0] rdata;
      logic        err;

      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      rstN    = 1'b0;
      $readmemh("tb/cpu_testdata.txt", testData);

      // Size the run from the records
      idx      = 0;
      words    = 0;
      programs = 0;
      while (testData[idx] != 32'd0) begin
         if (testData[idx] == 32'd1) begin
            words += testData[idx+1];
            programs++;
            idx += 2 + testData[idx+1] + `CPU_NREGS;
         end else if (testData[idx] == 32'd2) begin
            idx += 2;
         end else begin
            $display("The data file holds an unknown record tag at word %0d", idx);
            $display("Something failed");
            $fatal(1, "Bad data file");
         end
      end
      cycleLimit = words * 4 + 200 * (programs + 1);

      repeat (5) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;

      idx = 0;
      while (testData[idx] != 32'd0) begin
         if (testData[idx] == 32'd1) begin
            count = testData[idx+1];
            apbWrite(`REG_IMEM_ADDR, 32'd0);
            for (int i = 0; i < count; i++) begin
               apbWrite(`REG_IMEM_DATA, testData[idx+2+i]);
            end
            for (int r = 0; r < `CPU_NREGS; r++) begin
               expRegs[r] = testData[idx+2+count+r][`CPU_XLEN-1:0];
            end
            runToHalt();
            compareRegs();
            idx += 2 + count + `CPU_NREGS;
         end else begin
            apbAccess(1'b0, testData[idx+1][`CPU_APB_AW-1:0], 32'd0, rdata, err);
            checkValue("pslverr on bad read", {31'b0, err}, 32'd1);
            apbAccess(1'b1, testData[idx+1][`CPU_APB_AW-1:0], 32'hFFFF, rdata, err);
            checkValue("pslverr on bad write", {31'b0, err}, 32'd1);
            idx += 2;
         end
      end

      // Rerun of the last program must give the same registers
      runToHalt();
      compareRegs();

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: tb/cpu_testdata.txt
// Tag 1 = program: word count, program words, expected r0..r7 after halt
// Tag 2 = APB offset that must give pslverr; tag 0 ends the file
// Arithmetic, immediates and back-to-back chains
1 0A
6000 6205 65FD 1650 28C8 3B08 4D50 5FBE 5FDF F000
0000 0005 FFFD 0002 FFFD 0005 FFF8 0015
// Store and load at computed addresses
1 0B
6214 64AB 8443 679C 867F 7843 7A7F 1D28 6000 6E01 F000
0000 0014 00AB FF9C 00AB FF9C 0047 0001
// Offsets outside the register map
2 18
2 FC
2 02
// BEQZ not taken, then taken with two squashed slots
1 0F
6000 6201 6402 6603 6804 6A05 6C06 6E07
9042 5481 9002 6655 6866 5B50 F000
0000 0001 0003 0003 0004 0015 0006 0007
0

// File: sim.f
+incdir+source
source/cpuPkg.sv
source/cpuDebugIf.sv
source/cpuDebugRegs.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memWbStage.sv
source/cpuCore.sv
tb/cpu_props.sv
tb/cpuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, exit status follows the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpuTb -f sim.f -o cpuSim \
   && ./obj_dir/cpuSim \
   || exit 1
